// ==== mojo_top.f ====
verilog/mojo_pkg.sv
verilog/vga_timing.sv
verilog/pattern_gen.sv
verilog/status_uart.sv
verilog/main.sv
verilog/mojo_top.sv
test/mojo_top_assert.sv
test/mojo_top_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the mojo_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mojo_top_tb -f mojo_top.f \
  --Mdir build -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./build/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
exit 0

// ==== test/mojo_cases.txt ====
# P frame x y rgb : pattern sample at a pixel, rgb as {r,g,b}, all hex
# B byte : next status byte expected on avr_rx, hex
P 1 0 0 1
P 1 8 0 5
P 1 f 5 5
P 1 10 0 0
P 1 3 6 0
P 2 0 0 0
P 2 9 2 4
P 2 14 8 0
P 3 c 3 5
P 3 7 5 1
P 4 a 1 4
B 01
B 02
B 03

// ==== test/mojo_top_assert.sv ====
module mojo_top_assert #(
  parameter int H_SYNC = 96
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  hs,
  input logic                  avr_rx,
  input logic                  avr_rx_busy,
  input mojo_pkg::uart_state_t uart_state
);
  timeunit 1ns;
  timeprecision 100ps;

  import mojo_pkg::*;

  int low_len;  // consecutive low hs samples

  always_ff @(posedge clk) begin
    if (reset || hs) low_len <= 0;
    else             low_len <= low_len + 1;
  end

  hs_width: assert property (@(posedge clk) disable iff (reset)
    $rose(hs) |-> low_len == H_SYNC) else $error("hs low width wrong");

  // busy holds the line idle
  rx_held: assert property (@(posedge clk) disable iff (reset)
    (uart_state == IDLE && avr_rx_busy) |=> avr_rx) else $error("avr_rx left idle");

  stop_high: assert property (@(posedge clk) disable iff (reset)
    (uart_state == STOP) |-> avr_rx) else $error("avr_rx low in stop bit");

endmodule

bind main mojo_top_assert #(.H_SYNC(H_SYNC)) checks (
  .clk(clk), .reset(reset), .hs(hs), .avr_rx(avr_rx), .avr_rx_busy(avr_rx_busy),
  .uart_state(status.state)
);

// ==== test/mojo_top_tb.sv ====
module mojo_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int H_ACTIVE = 16;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BACK   = 3;
  localparam int V_ACTIVE = 6;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int CPB      = 4;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int T_RESET = 0, T_SYNC = 1, T_PATTERN = 2, T_LED = 3, T_BYTES = 4, T_BUSY = 5;

  logic clk = 1'b0;
  logic reset, cclk, spi_ss, spi_mosi, spi_sck, avr_tx, avr_rx_busy;
  wire [7:0] led;
  wire [3:0] spi_channel;
  wire spi_miso, avr_rx, sdram_clk, sdram_cle, sdram_dqm, sdram_cs;
  wire sdram_we, sdram_cas, sdram_ras, vga_hs, vga_vs, vga_r, vga_g, vga_b;
  wire [1:0] sdram_ba;
  wire [12:0] sdram_a;
  tri [7:0] sdram_dq;

  int errors = 0;
  int checks = 0;
  int test_errs[6];
  string test_names[6] = '{"reset values", "sync timing", "pattern samples",
                           "led frame count", "status bytes", "busy hold-off"};
  int s_frame[$], s_x[$], s_y[$], s_rgb[$], s_hit[$];
  logic [7:0] exp_bytes[$];
  logic [7:0] rx_bytes[$];
  logic [2:0] pre_rgb[$];  // pins seen before the vsync edge
  int cycle = 0;
  int busy_until = 0;
  logic [31:0] rng = 32'd22102;

  mojo_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .CLKS_PER_BIT(CPB)
  ) uut (.*);

  always #50 clk = ~clk;

  // busy stimulus, window set by the model loop
  always @(posedge clk) begin
    cycle <= cycle + 1;
    avr_rx_busy <= (cycle < busy_until);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  task automatic check_value(input int test_id, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs[test_id]++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // compare rgb with every case sample at this raster position
  task automatic check_samples(input int f, input int x, input int y,
                               input logic [2:0] rgb);
    foreach (s_x[k]) begin
      if (!s_hit[k] && s_x[k] == x && s_y[k] == y && s_frame[k] == f) begin
        check_value(T_PATTERN, "rgb", rgb, s_rgb[k]);
        s_hit[k] = 1;
      end
    end
  endtask

  task automatic abort_run(input string why);
    $display("TIMEOUT: %s", why);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic load_cases();
    int fd, code, f, x, y, c;
    logic [7:0] tag;
    string line;
    fd = $fopen("test/mojo_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open test/mojo_cases.txt");
      errors++;
      return;
    end
    for (int n = 0; n < 200; n++) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(line, fd);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%h %h %h %h", f, x, y, c);
        s_frame.push_back(f);
        s_x.push_back(x);
        s_y.push_back(y);
        s_rgb.push_back(c);
        s_hit.push_back(0);
      end else begin
        code = $fscanf(fd, "%h", c);
        exp_bytes.push_back(c[7:0]);
      end
    end
    $fclose(fd);
  endtask

  // ======================================================================
  // 8N1 decoder on avr_rx
  // ======================================================================
  initial begin : rx_decode
    int waited;
    bit found;
    logic rx_last, busy_last;
    logic [7:0] b;
    waited = 0;
    while (reset !== 1'b0) begin
      @(negedge clk);
      if (++waited > 100) abort_run("reset never released");
    end
    rx_last = 1'b1;
    busy_last = 1'b0;
    forever begin
      waited = 0;
      found = 0;
      while (!found) begin
        @(negedge clk);
        if (rx_last && !avr_rx) found = 1;
        else busy_last = avr_rx_busy;
        rx_last = avr_rx;
        if (!found && ++waited > 1000) abort_run("no start bit on avr_rx");
      end
      check_value(T_BUSY, "avr_rx_busy", busy_last, 0);
      repeat (CPB / 2) @(negedge clk);
      check_value(T_BYTES, "avr_rx start", avr_rx, 0);
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        b[i] = avr_rx;  // lsb first
      end
      repeat (CPB) @(negedge clk);
      check_value(T_BYTES, "avr_rx stop", avr_rx, 1);
      rx_bytes.push_back(b);
      rx_last = avr_rx;
    end
  end

  // ======================================================================
  // main sequence with the raster model
  // ======================================================================
  initial begin
    int waited, mx, my, mf, failed, p;
    logic vs_last;
    {reset, cclk, spi_ss, spi_mosi, spi_sck, avr_tx, avr_rx_busy} = 7'b1010000;
    load_cases();
    repeat (4) @(negedge clk);
    check_value(T_RESET, "vga_hs", vga_hs, 1);
    check_value(T_RESET, "vga_vs", vga_vs, 1);
    check_value(T_RESET, "avr_rx", avr_rx, 1);
    check_value(T_RESET, "rgb", {vga_r, vga_g, vga_b}, 0);
    check_value(T_RESET, "led", led, 0);
    check_value(T_RESET, "sdram_cs", sdram_cs, 1);
    check_value(T_RESET, "spi_channel", spi_channel, 4'hf);
    check_value(T_RESET, "spi_miso", spi_miso, 0);
    check_value(T_RESET, "sdram_clk", sdram_clk, 1);  // clk low here
    check_value(T_RESET, "sdram_cle", sdram_cle, 0);
    check_value(T_RESET, "sdram_dqm", sdram_dqm, 1);
    check_value(T_RESET, "sdram_we", sdram_we, 1);
    check_value(T_RESET, "sdram_cas", sdram_cas, 1);
    check_value(T_RESET, "sdram_ras", sdram_ras, 1);
    check_value(T_RESET, "sdram_ba", sdram_ba, 0);
    check_value(T_RESET, "sdram_a", sdram_a, 0);
    @(posedge clk);
    reset <= 1'b0;

    waited = 0;
    vs_last = 1'b1;
    @(negedge clk);
    while (!(vs_last && !vga_vs)) begin
      vs_last = vga_vs;
      pre_rgb.push_back({vga_r, vga_g, vga_b});
      @(negedge clk);
      if (++waited > 3000) abort_run("vga_vs never fell");
    end
    mx = 0;
    my = V_ACTIVE + V_FRONT;
    mf = 1;

    // frame 1 rows above the vsync edge
    foreach (pre_rgb[i]) begin
      p = my * H_TOTAL - pre_rgb.size() + i;
      if (p >= 0) check_samples(1, p % H_TOTAL, p / H_TOTAL, pre_rgb[i]);
    end

    for (int n = 0; n < 6 * H_TOTAL * V_TOTAL; n++) begin
      check_value(T_SYNC, "vga_hs", vga_hs,
                  !(mx >= H_ACTIVE + H_FRONT && mx < H_ACTIVE + H_FRONT + H_SYNC));
      check_value(T_SYNC, "vga_vs", vga_vs,
                  !(my >= V_ACTIVE + V_FRONT && my < V_ACTIVE + V_FRONT + V_SYNC));
      check_value(T_LED, "led", led, mf);
      check_samples(mf, mx, my, {vga_r, vga_g, vga_b});
      if (mx == H_TOTAL - 4 && my == V_TOTAL - 1) begin  // just before frame start
        rng = xorshift32(rng);
        busy_until = cycle + 6 + int'(rng % 31);
      end
      @(negedge clk);
      if (++mx == H_TOTAL) begin
        mx = 0;
        if (++my == V_TOTAL) begin
          my = 0;
          mf++;
        end
      end
    end

    foreach (s_hit[k]) begin
      if (!s_hit[k]) begin
        $display("pattern sample %0d was never reached", k);
        errors++;
        test_errs[T_PATTERN]++;
      end
    end
    foreach (exp_bytes[k]) begin
      if (k >= rx_bytes.size()) begin
        $display("status byte %0d never arrived on avr_rx", k);
        errors++;
        test_errs[T_BYTES]++;
      end else begin
        check_value(T_BYTES, "avr_rx byte", rx_bytes[k], exp_bytes[k]);
      end
    end

    failed = 0;
    foreach (test_names[t]) begin
      if (test_errs[t] != 0) failed++;
      $display("test %-16s %s (%0d errors)", test_names[t],
               (test_errs[t] == 0) ? "ok" : "failed", test_errs[t]);
    end
    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             6, failed, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog/main.sv ====
module main #(
  parameter int H_ACTIVE     = 640,
  parameter int H_FRONT      = 16,
  parameter int H_SYNC       = 96,
  parameter int H_BACK       = 48,
  parameter int V_ACTIVE     = 480,
  parameter int V_FRONT      = 10,
  parameter int V_SYNC       = 2,
  parameter int V_BACK       = 33,
  parameter int CLKS_PER_BIT = 434
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             avr_rx_busy,
  output mojo_pkg::frame_t led,
  output logic             avr_rx,
  output mojo_pkg::rgb_t   rgb,
  output logic             hs,
  output logic             vs,
  inout  wire  [7:0]       sdram_dq,
  output logic             sdram_clk,
  output logic             sdram_cle,
  output logic             sdram_dqm,
  output logic             sdram_cs,
  output logic             sdram_we,
  output logic             sdram_cas,
  output logic             sdram_ras,
  output logic [1:0]       sdram_ba,
  output logic [12:0]      sdram_a,
  output logic             spi_miso,
  output logic [3:0]       spi_channel
);

  import mojo_pkg::*;

  vga_pos_t pos;
  logic     hs_raw;
  logic     vs_raw;
  frame_t   frame_cnt;
  frame_t   frame_cur;

  // count including a frame start in this cycle, so pixel (0,0) and the
  // status byte see the same value as led during the rest of the frame
  assign frame_cur = pos.frame_start ? frame_cnt + 1'b1 : frame_cnt;
  assign led       = frame_cnt;

  // ======================================================================
  // frame counter and sync delay
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_cnt <= '0;
      hs        <= 1'b1;
      vs        <= 1'b1;
    end else begin
      frame_cnt <= frame_cur;
      hs        <= hs_raw;  // match pattern_gen latency
      vs        <= vs_raw;
    end
  end

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) timing (
    .clk(clk), .reset(reset), .pos(pos), .hs(hs_raw), .vs(vs_raw)
  );

  pattern_gen pattern (
    .clk(clk), .reset(reset), .pos(pos), .frame(frame_cur), .rgb(rgb)
  );

  status_uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) status (
    .clk(clk), .reset(reset), .frame_start(pos.frame_start), .frame(frame_cur),
    .busy(avr_rx_busy), .tx(avr_rx)
  );

  // sdram idle, deselected NOP; dq left floating
  assign sdram_clk = ~clk;
  assign sdram_cle = 1'b0;
  assign sdram_dqm = 1'b1;
  assign sdram_cs  = 1'b1;
  assign sdram_we  = 1'b1;
  assign sdram_cas = 1'b1;
  assign sdram_ras = 1'b1;
  assign sdram_ba  = '0;
  assign sdram_a   = '0;

  assign spi_miso    = 1'b0;
  assign spi_channel = 4'hf;  // no adc channel

endmodule

// ==== verilog/mojo_pkg.sv ====
package mojo_pkg;

  // ======================================================================
  // widths with a meaning
  // ======================================================================
  typedef logic [10:0] coord_t;   // pixel or line count
  typedef logic [7:0]  frame_t;   // frame count
  typedef logic [2:0]  rgb_t;     // {r, g, b}

  // position of the current pixel, all fields from the same counter state
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   active;
    logic   frame_start;
  } vga_pos_t;

  // ======================================================================
  // status transmitter states
  // ======================================================================
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

// ==== verilog/mojo_top.sv ====
module mojo_top #(
  parameter int H_ACTIVE     = 640,
  parameter int H_FRONT      = 16,
  parameter int H_SYNC       = 96,
  parameter int H_BACK       = 48,
  parameter int V_ACTIVE     = 480,
  parameter int V_FRONT      = 10,
  parameter int V_SYNC       = 2,
  parameter int V_BACK       = 33,
  parameter int CLKS_PER_BIT = 434
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cclk,
  output mojo_pkg::frame_t led,
  output logic             spi_miso,
  input  logic             spi_ss,
  input  logic             spi_mosi,
  input  logic             spi_sck,
  output logic [3:0]       spi_channel,
  input  logic             avr_tx,
  output logic             avr_rx,
  input  logic             avr_rx_busy,
  output logic             sdram_clk,
  output logic             sdram_cle,
  output logic             sdram_dqm,
  output logic             sdram_cs,
  output logic             sdram_we,
  output logic             sdram_cas,
  output logic             sdram_ras,
  output logic [1:0]       sdram_ba,
  output logic [12:0]      sdram_a,
  inout  wire  [7:0]       sdram_dq,
  output logic             vga_hs,
  output logic             vga_vs,
  output logic             vga_r,
  output logic             vga_g,
  output logic             vga_b
);

  import mojo_pkg::*;

  rgb_t main_rgb;

  main #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) core (
    .clk(clk),
    .reset(reset),
    .avr_rx_busy(avr_rx_busy),
    .led(led),
    .avr_rx(avr_rx),
    .rgb(main_rgb),
    .hs(vga_hs),
    .vs(vga_vs),
    .sdram_dq(sdram_dq),
    .sdram_clk(sdram_clk),
    .sdram_cle(sdram_cle),
    .sdram_dqm(sdram_dqm),
    .sdram_cs(sdram_cs),
    .sdram_we(sdram_we),
    .sdram_cas(sdram_cas),
    .sdram_ras(sdram_ras),
    .sdram_ba(sdram_ba),
    .sdram_a(sdram_a),
    .spi_miso(spi_miso),
    .spi_channel(spi_channel)
  );

  // one bit per colour at the pins
  assign vga_r = main_rgb[2];
  assign vga_g = main_rgb[1];
  assign vga_b = main_rgb[0];

endmodule

// ==== verilog/pattern_gen.sv ====
module pattern_gen (
  input  logic               clk,
  input  logic               reset,
  input  mojo_pkg::vga_pos_t pos,
  input  mojo_pkg::frame_t   frame,
  output mojo_pkg::rgb_t     rgb
);

  import mojo_pkg::*;

  rgb_t bars;

  // colour bars from x, blue band flips with frame parity
  always_comb begin
    bars[2] = pos.x[3];             // r
    bars[1] = pos.x[4];             // g
    bars[0] = pos.y[3] ^ frame[0];  // b
  end

  // ======================================================================
  // output register, one cycle behind pos
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      rgb <= '0;
    end else if (pos.active) begin
      rgb <= bars;
    end else begin
      rgb <= '0;  // blanking
    end
  end

endmodule

// ==== verilog/status_uart.sv ====
module status_uart #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_start,
  input  mojo_pkg::frame_t frame,
  input  logic             busy,
  output logic             tx
);

  import mojo_pkg::*;

  localparam int TIMER_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [TIMER_W-1:0] BIT_LAST = TIMER_W'(CLKS_PER_BIT - 1);

  uart_state_t        state;
  logic [TIMER_W-1:0] bit_timer;
  logic [2:0]         bit_idx;
  frame_t             shift;
  frame_t             pend_byte;  // latest count not yet sent
  logic               pending;

  wire bit_done = (bit_timer == BIT_LAST);

  // ======================================================================
  // 8N1 transmitter
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      bit_timer <= '0;
      bit_idx   <= '0;
      pending   <= 1'b0;
      tx        <= 1'b1;
    end else begin
      bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
      case (state)
        IDLE: begin
          bit_timer <= '0;
          if (pending && !busy) begin  // busy only matters here
            shift   <= pend_byte;
            pending <= 1'b0;
            tx      <= 1'b0;           // start bit
            state   <= START;
          end
        end
        START: if (bit_done) begin
          bit_idx <= '0;
          tx      <= shift[0];
          state   <= DATA;
        end
        DATA: if (bit_done) begin
          shift   <= shift >> 1;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            tx    <= 1'b1;  // stop bit
            state <= STOP;
          end else begin
            tx <= shift[1];
          end
        end
        STOP: if (bit_done) state <= IDLE;
        default: state <= IDLE;
      endcase
      // newer frame wins over a pending one
      if (frame_start) begin
        pending   <= 1'b1;
        pend_byte <= frame;
      end
    end
  end

endmodule

// ==== verilog/vga_timing.sv ====
module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic               clk,
  input  logic               reset,
  output mojo_pkg::vga_pos_t pos,
  output logic               hs,
  output logic               vs
);

  import mojo_pkg::*;

  localparam coord_t H_LAST   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
  localparam coord_t V_LAST   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
  localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FRONT);
  localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FRONT);
  localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

  coord_t x_cnt;
  coord_t y_cnt;

  // ======================================================================
  // raster counters
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (x_cnt == H_LAST) begin
      x_cnt <= '0;
      if (y_cnt == V_LAST) y_cnt <= '0;
      else                 y_cnt <= y_cnt + 1'b1;  // next line
    end else begin
      x_cnt <= x_cnt + 1'b1;
    end
  end

  // ======================================================================
  // registered position and sync, all from the same counter state
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      pos <= '0;
      hs  <= 1'b1;  // inactive
      vs  <= 1'b1;
    end else begin
      pos.x           <= x_cnt;
      pos.y           <= y_cnt;
      pos.active      <= (x_cnt < coord_t'(H_ACTIVE)) && (y_cnt < coord_t'(V_ACTIVE));
      pos.frame_start <= (x_cnt == '0) && (y_cnt == '0);
      // negative polarity sync pulses
      hs <= !((x_cnt >= HS_START) && (x_cnt < HS_END));
      vs <= !((y_cnt >= VS_START) && (y_cnt < VS_END));
    end
  end

endmodule
